// File: verilog/eeprom_pkg.sv
// Shared types and constants for the two-wire EEPROM master.
// Modules refer to these by scoped name, e.g. eeprom_pkg::req_t.

package eeprom_pkg;

    localparam int ADDR_W = 11;    // 2 KiB byte address space
    localparam int DATA_W = 8;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // one host request, held stable for the whole transaction
    typedef struct packed {
        logic  is_read;
        addr_t addr;
        data_t wr_data;    // ignored for reads
    } req_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_TX_BYTE,    // 8 bits out plus released ack slot
        OP_RX_BYTE     // 8 bits in plus released ack slot
    } bus_op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        FINISH
    } seq_state_t;

    // one-cycle strobes at fixed points of the SCL period
    typedef struct packed {
        logic low_mid;     // middle of low half, sda may change
        logic rise;        // last cycle before scl rises
        logic high_mid;    // middle of high half, sda sampled
        logic fall;        // last cycle before scl falls
    } scl_tick_t;

endpackage

// File: verilog/eeprom_req_capture.sv
// Holds one host write or read request until the bus transaction ends.
// Strobes are only looked at while nothing is pending.

`timescale 1ns/1ps

module eeprom_req_capture (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr,
    input  logic               rd,
    input  eeprom_pkg::addr_t  addr,
    input  eeprom_pkg::data_t  wr_data,
    input  logic               finish,
    output logic               req_valid,
    output eeprom_pkg::req_t   req
);

    logic take;    // accept a strobe this cycle

    assign take = !req_valid && (wr || rd);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else if (take)
        begin
            req_valid <= 1'b1;
        end
        else if (finish)
        begin
            req_valid <= 1'b0;    // free for the next strobe
        end
    end

    // request payload, loaded only when a strobe is accepted
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            req.is_read <= !wr;    // write wins when both are high
            req.addr    <= addr;
            req.wr_data <= wr_data;
        end
    end

endmodule

// File: verilog/eeprom_sequencer.sv
// Transaction FSM. Walks the write or random read sequence, handing one
// bus operation at a time to the bit engine, and keeps the last read byte.

`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  eeprom_pkg::req_t     req,
    output logic                 op_go,
    output eeprom_pkg::bus_op_t  op,
    output eeprom_pkg::data_t    tx_byte,
    input  logic                 op_done,
    input  eeprom_pkg::data_t    rx_byte,
    output logic                 bus_run,
    output logic                 finish,
    output eeprom_pkg::data_t    rd_data
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t next_state;
    eeprom_pkg::data_t      ctrl_wr;
    eeprom_pkg::data_t      ctrl_rd;

    // device code, block bits a10..a8, r/w bit
    assign ctrl_wr = {eeprom_pkg::DEVICE_CODE, req.addr[eeprom_pkg::ADDR_W-1:8], 1'b0};
    assign ctrl_rd = {eeprom_pkg::DEVICE_CODE, req.addr[eeprom_pkg::ADDR_W-1:8], 1'b1};

    assign finish = (state == eeprom_pkg::FINISH);

    always_comb
    begin
        next_state = state;
        case (state)
            eeprom_pkg::IDLE:    if (req_valid) next_state = eeprom_pkg::START;
            eeprom_pkg::START:   if (op_done) next_state = eeprom_pkg::CTRL_WR;
            eeprom_pkg::CTRL_WR: if (op_done) next_state = eeprom_pkg::ADDR;
            eeprom_pkg::ADDR:
            begin
                if (op_done)
                    next_state = req.is_read ? eeprom_pkg::RESTART : eeprom_pkg::DATA_WR;
            end
            eeprom_pkg::DATA_WR: if (op_done) next_state = eeprom_pkg::STOP;
            eeprom_pkg::RESTART: if (op_done) next_state = eeprom_pkg::CTRL_RD;
            eeprom_pkg::CTRL_RD: if (op_done) next_state = eeprom_pkg::DATA_RD;
            eeprom_pkg::DATA_RD: if (op_done) next_state = eeprom_pkg::STOP;
            eeprom_pkg::STOP:    if (op_done) next_state = eeprom_pkg::FINISH;
            default:             next_state = eeprom_pkg::IDLE;    // FINISH lasts one cycle
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= eeprom_pkg::IDLE;
            op_go   <= 1'b0;
            bus_run <= 1'b0;
            rd_data <= '0;
        end
        else
        begin
            state <= next_state;
            // every state change into an op state launches its operation
            op_go <= (next_state != state) && (next_state != eeprom_pkg::IDLE)
                     && (next_state != eeprom_pkg::FINISH);
            // scl starts one cycle after the start op is handed over
            bus_run <= (state != eeprom_pkg::IDLE) && (state != eeprom_pkg::FINISH)
                       && !((state == eeprom_pkg::STOP) && op_done);
            if ((state == eeprom_pkg::DATA_RD) && op_done)
                rd_data <= rx_byte;
        end
    end

    // operation and byte for the state being entered
    always_ff @(posedge clk)
    begin
        case (next_state)
            eeprom_pkg::START,
            eeprom_pkg::RESTART: op <= eeprom_pkg::OP_START;
            eeprom_pkg::CTRL_WR:
            begin
                op      <= eeprom_pkg::OP_TX_BYTE;
                tx_byte <= ctrl_wr;
            end
            eeprom_pkg::ADDR:
            begin
                op      <= eeprom_pkg::OP_TX_BYTE;
                tx_byte <= req.addr[7:0];    // low address byte
            end
            eeprom_pkg::DATA_WR:
            begin
                op      <= eeprom_pkg::OP_TX_BYTE;
                tx_byte <= req.wr_data;
            end
            eeprom_pkg::CTRL_RD:
            begin
                op      <= eeprom_pkg::OP_TX_BYTE;
                tx_byte <= ctrl_rd;
            end
            eeprom_pkg::DATA_RD: op <= eeprom_pkg::OP_RX_BYTE;
            eeprom_pkg::STOP:    op <= eeprom_pkg::OP_STOP;
            default:             op <= op;
        endcase
    end

endmodule

// File: verilog/eeprom_bit_engine.sv
// Runs one bus operation (start, stop, byte out, byte in) on the SCL
// phase ticks. SDA is set on low_mid and sampled on high_mid; start and
// stop move SDA on high_mid instead. op_done comes on the final high_mid.

`timescale 1ns/1ps

module eeprom_bit_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_go,
    input  eeprom_pkg::bus_op_t    op,
    input  eeprom_pkg::data_t      tx_byte,
    input  eeprom_pkg::scl_tick_t  tick,
    input  logic                   sda_in,
    output logic                   sda_next,
    output logic                   sda_drive,
    output logic                   op_done,
    output eeprom_pkg::data_t      rx_byte
);

    localparam logic [3:0] ACK_SLOT = 4'd8;    // ninth bit of every byte

    logic                active;
    eeprom_pkg::bus_op_t cur_op;
    logic [3:0]          bit_cnt;
    eeprom_pkg::data_t   shift_reg;
    logic                last_phase;
    logic                data_bit;    // one of the 8 data bits, not the ack

    assign data_bit   = (bit_cnt != ACK_SLOT);
    assign last_phase = (cur_op == eeprom_pkg::OP_START) || (cur_op == eeprom_pkg::OP_STOP)
                        || !data_bit;
    assign op_done    = active && tick.high_mid && last_phase;
    assign rx_byte    = shift_reg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active    <= 1'b0;
            cur_op    <= eeprom_pkg::OP_START;
            bit_cnt   <= '0;
            sda_next  <= 1'b1;
            sda_drive <= 1'b0;    // line released, pulled high
        end
        else if (op_go)
        begin
            active  <= 1'b1;
            cur_op  <= op;
            bit_cnt <= '0;
        end
        else if (active && tick.low_mid)
        begin
            case (cur_op)
                eeprom_pkg::OP_START:
                begin
                    sda_drive <= 1'b1;    // sda high before a repeated start
                    sda_next  <= 1'b1;
                end
                eeprom_pkg::OP_STOP:
                begin
                    sda_drive <= 1'b1;    // low so it can rise with scl high
                    sda_next  <= 1'b0;
                end
                eeprom_pkg::OP_TX_BYTE:
                begin
                    sda_drive <= data_bit;    // let go for the ack slot
                    sda_next  <= shift_reg[eeprom_pkg::DATA_W-1];
                end
                default:
                begin
                    sda_drive <= 1'b0;    // slave drives data, master does not ack
                end
            endcase
        end
        else if (active && tick.high_mid)
        begin
            case (cur_op)
                eeprom_pkg::OP_START:
                begin
                    sda_drive <= 1'b1;    // falling sda with scl high
                    sda_next  <= 1'b0;
                end
                eeprom_pkg::OP_STOP:
                begin
                    sda_drive <= 1'b0;    // release, pull-up gives the rising edge
                    sda_next  <= 1'b1;
                end
                default:
                begin
                    if (data_bit)
                        bit_cnt <= bit_cnt + 1'b1;
                end
            endcase
            if (last_phase)
                active <= 1'b0;
        end
    end

    // byte shifter, msb first both ways
    always_ff @(posedge clk)
    begin
        if (op_go)
            shift_reg <= tx_byte;
        else if (active && data_bit && tick.low_mid && (cur_op == eeprom_pkg::OP_TX_BYTE))
            shift_reg <= {shift_reg[eeprom_pkg::DATA_W-2:0], 1'b0};
        else if (active && data_bit && tick.high_mid && (cur_op == eeprom_pkg::OP_RX_BYTE))
            shift_reg <= {shift_reg[eeprom_pkg::DATA_W-2:0], sda_in};
    end

endmodule

// File: verilog/eeprom_bus_driver.sv
// SCL generator and SDA pin registers. SCL runs only while bus_run is high
// and starts with a high half; it rests high otherwise.
// SCL_HALF_CYCLES is the half period in CLK cycles, at least 2.

`timescale 1ns/1ps

module eeprom_bus_driver #(
    parameter int SCL_HALF_CYCLES = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bus_run,
    input  logic                   sda_next,
    input  logic                   sda_drive,
    output eeprom_pkg::scl_tick_t  tick,
    output logic                   scl,
    output logic                   sda_out,
    output logic                   sda_oe,
    input  logic                   sda_in,
    output logic                   sda_sampled
);

    localparam int CNT_W = $clog2(SCL_HALF_CYCLES);
    localparam logic [CNT_W-1:0] MID  = CNT_W'((SCL_HALF_CYCLES - 1) / 2);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SCL_HALF_CYCLES - 1);

    logic [CNT_W-1:0] half_cnt;    // position inside the current half

    always_comb
    begin
        tick.low_mid  = bus_run && !scl && (half_cnt == MID);
        tick.rise     = bus_run && !scl && (half_cnt == LAST);
        tick.high_mid = bus_run && scl && (half_cnt == MID);
        tick.fall     = bus_run && scl && (half_cnt == LAST);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            half_cnt <= '0;
            scl      <= 1'b1;
            sda_out  <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            if (!bus_run)
            begin
                half_cnt <= '0;    // park with scl high
                scl      <= 1'b1;
            end
            else if (tick.rise || tick.fall)
            begin
                half_cnt <= '0;
                scl      <= ~scl;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
            sda_out <= sda_next;
            sda_oe  <= sda_drive;
        end
    end

    always_ff @(posedge clk)
    begin
        sda_sampled <= sda_in;    // one register on the pad input
    end

endmodule

// File: verilog/eeprom_master.sv
// Top level of the two-wire EEPROM master. A host strobes wr or rd with
// addr and wr_data; done pulses once the bus transaction has finished and
// rd_data then holds the byte read. busy is high while a request is held.

`timescale 1ns/1ps

module eeprom_master #(
    parameter int SCL_HALF_CYCLES = 4
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               wr,
    input  logic               rd,
    input  eeprom_pkg::addr_t  addr,
    input  eeprom_pkg::data_t  wr_data,
    output eeprom_pkg::data_t  rd_data,
    output logic               done,
    output logic               busy,
    output logic               scl,
    output logic               sda_out,
    output logic               sda_oe,
    input  logic               sda_in
);

    logic                  req_valid;
    eeprom_pkg::req_t      req;
    logic                  finish;
    logic                  op_go;
    eeprom_pkg::bus_op_t   op;
    eeprom_pkg::data_t     tx_byte;
    logic                  op_done;
    eeprom_pkg::data_t     rx_byte;
    logic                  bus_run;
    eeprom_pkg::scl_tick_t tick;
    logic                  sda_next;
    logic                  sda_drive;
    logic                  sda_sampled;

    assign done = finish;
    assign busy = req_valid;

    eeprom_req_capture req_capture_i (
        .clk(CLK), .reset(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .finish(finish), .req_valid(req_valid), .req(req)
    );

    eeprom_sequencer sequencer_i (
        .clk(CLK), .reset(RESET), .req_valid(req_valid), .req(req),
        .op_go(op_go), .op(op), .tx_byte(tx_byte), .op_done(op_done), .rx_byte(rx_byte),
        .bus_run(bus_run), .finish(finish), .rd_data(rd_data)
    );

    eeprom_bit_engine bit_engine_i (
        .clk(CLK), .reset(RESET), .op_go(op_go), .op(op), .tx_byte(tx_byte), .tick(tick),
        .sda_in(sda_sampled), .sda_next(sda_next), .sda_drive(sda_drive),
        .op_done(op_done), .rx_byte(rx_byte)
    );

    eeprom_bus_driver #(
        .SCL_HALF_CYCLES(SCL_HALF_CYCLES)
    ) bus_driver_i (
        .clk(CLK), .reset(RESET), .bus_run(bus_run), .sda_next(sda_next),
        .sda_drive(sda_drive), .tick(tick), .scl(scl), .sda_out(sda_out),
        .sda_oe(sda_oe), .sda_in(sda_in), .sda_sampled(sda_sampled)
    );

endmodule

// File: verification/eeprom_model.sv
// Behavioral two-wire serial EEPROM with 2 KiB of byte storage, for the testbench.
// Oversamples SCL and SDA on the testbench clock, acks every byte sent to it,
// answers random reads and counts start and stop conditions.

`timescale 1ns/1ps

module eeprom_model (
    input  logic clk,
    input  logic scl,
    input  logic sda,            // resolved open-drain line
    output logic sda_low,        // pulls the line low while high
    output int   start_count,
    output int   stop_count,
    output logic bad_code        // a control byte had the wrong device code
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CTRL,
        PH_ADDR,
        PH_WDATA,
        PH_RDATA
    } phase_t;

    logic [7:0]        mem [0:(1 << eeprom_pkg::ADDR_W) - 1] = '{default: 8'h00};
    phase_t            phase = PH_IDLE;
    logic              scl_q = 1'b1;
    logic              sda_q = 1'b1;
    logic [3:0]        bit_cnt = 4'd0;
    logic [7:0]        shift_in = 8'h00;
    logic [7:0]        shift_out = 8'h00;
    logic              in_ack = 1'b0;
    eeprom_pkg::addr_t ptr = '0;
    logic              pull_low = 1'b0;
    int                starts = 0;
    int                stops = 0;
    logic              code_err = 1'b0;

    assign sda_low     = pull_low;
    assign start_count = starts;
    assign stop_count  = stops;
    assign bad_code    = code_err;

    always @(posedge clk)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda)
        begin
            starts   <= starts + 1;    // also covers the repeated start
            phase    <= PH_CTRL;
            bit_cnt  <= 4'd0;
            in_ack   <= 1'b0;
            pull_low <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            stops    <= stops + 1;
            phase    <= PH_IDLE;
            in_ack   <= 1'b0;
            pull_low <= 1'b0;
        end
        else if (scl && !scl_q)
        begin
            if ((phase != PH_IDLE) && (bit_cnt < 4'd8))
            begin
                shift_in <= {shift_in[6:0], sda};
                bit_cnt  <= bit_cnt + 4'd1;
            end
        end
        else if (!scl && scl_q)
        begin
            if (in_ack)
            begin
                in_ack    <= 1'b0;    // ack slot over
                bit_cnt   <= 4'd0;
                shift_out <= mem[ptr];
                pull_low  <= (phase == PH_RDATA) && !mem[ptr][7];
            end
            else if (bit_cnt == 4'd8)
            begin
                case (phase)
                    PH_CTRL:
                    begin
                        if (shift_in[7:4] != eeprom_pkg::DEVICE_CODE)
                            code_err <= 1'b1;
                        ptr[eeprom_pkg::ADDR_W-1:8] <= shift_in[3:1];
                        phase    <= shift_in[0] ? PH_RDATA : PH_ADDR;
                        in_ack   <= 1'b1;
                        pull_low <= 1'b1;
                    end
                    PH_ADDR:
                    begin
                        ptr[7:0] <= shift_in;
                        phase    <= PH_WDATA;
                        in_ack   <= 1'b1;
                        pull_low <= 1'b1;
                    end
                    PH_WDATA:
                    begin
                        mem[ptr] <= shift_in;
                        phase    <= PH_IDLE;
                        in_ack   <= 1'b1;
                        pull_low <= 1'b1;
                    end
                    default:
                    begin
                        phase    <= PH_IDLE;    // read byte sent, master gives no ack
                        pull_low <= 1'b0;
                    end
                endcase
            end
            else if ((phase == PH_RDATA) && (bit_cnt != 4'd0))
            begin
                pull_low  <= !shift_out[6];    // next bit, msb first
                shift_out <= {shift_out[6:0], 1'b0};
            end
        end
    end

endmodule

// File: verification/eeprom_master_tb.sv
// Directed testbench for the two-wire EEPROM master. A behavioral EEPROM sits
// on the resolved open-drain SDA line; each test task drives the host side and
// checks read data, model memory, start/stop counts and idle bus levels.

`timescale 1ns/1ps

module eeprom_master_tb;

    localparam int DONE_TIMEOUT = 4000;    // CLK cycles for one transaction
    localparam int STOP_TIMEOUT = 20;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    eeprom_pkg::addr_t addr;
    eeprom_pkg::data_t wr_data;
    eeprom_pkg::data_t rd_data;
    logic              done;
    logic              busy;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              sda_line;
    logic              model_low;
    int                start_count;
    int                stop_count;
    logic              bad_code;
    int                done_count = 0;
    logic [15:0]       lfsr = 16'd53;

    // open-drain line with pull-up
    assign sda_line = sda_oe ? sda_out : !model_low;

    eeprom_master #(
        .SCL_HALF_CYCLES(4)
    ) eeprom_master_i (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .done(done), .busy(busy), .scl(scl), .sda_out(sda_out),
        .sda_oe(sda_oe), .sda_in(sda_line)
    );

    eeprom_model model_i (
        .clk(CLK), .scl(scl), .sda(sda_line), .sda_low(model_low),
        .start_count(start_count), .stop_count(stop_count), .bad_code(bad_code)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (done === 1'b1)
            done_count <= done_count + 1;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input eeprom_pkg::data_t got,
                              input eeprom_pkg::data_t exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        while (done !== 1'b1)
        begin
            @(negedge CLK);
            cycles++;
            if (cycles > DONE_TIMEOUT)
                fail_run({"timed out waiting for done after ", what});
        end
    endtask

    task automatic wait_stop(input int expected);
        int cycles;
        cycles = 0;
        while (stop_count < expected)
        begin
            @(negedge CLK);
            cycles++;
            if (cycles > STOP_TIMEOUT)
                fail_run("no stop condition seen on the bus after done");
        end
    endtask

    // one host request with its own start and stop counts
    task automatic transfer(input logic is_read, input eeprom_pkg::addr_t a,
                            input eeprom_pkg::data_t d, output eeprom_pkg::data_t got);
        int starts0;
        int stops0;
        starts0 = start_count;
        stops0  = stop_count;
        @(negedge CLK);
        addr    = a;
        wr_data = d;
        wr      = !is_read;
        rd      = is_read;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_level("busy", busy, 1'b1);
        wait_done(is_read ? "read" : "write");
        got = rd_data;
        wait_stop(stops0 + 1);
        check_count("start_count delta", start_count - starts0, is_read ? 2 : 1);
        check_count("stop_count delta", stop_count - stops0, 1);
        check_level("scl", scl, 1'b1);    // bus parked between transfers
        check_level("sda_oe", sda_oe, 1'b0);
        check_level("busy", busy, 1'b0);
    endtask

    task automatic after_reset_state();
        check_level("busy", busy, 1'b0);
        check_level("done", done, 1'b0);
        check_level("sda_oe", sda_oe, 1'b0);
        check_level("scl", scl, 1'b1);
        check_data("rd_data", rd_data, 8'h00);
    endtask

    task automatic write_then_read();
        eeprom_pkg::data_t got;
        transfer(1'b0, 11'h0A5, 8'h3C, got);
        transfer(1'b1, 11'h0A5, 8'h00, got);
        check_data("rd_data", got, 8'h3C);
        check_data("model mem[0x0a5]", model_i.mem[11'h0A5], 8'h3C);
    endtask

    task automatic random_addresses();
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t d;
        eeprom_pkg::data_t got;
        logic [31:0]       bits;
        for (int i = 0; i < 10; i++)
        begin
            bits = rand_bits(eeprom_pkg::ADDR_W);
            a    = bits[eeprom_pkg::ADDR_W-1:0];
            if ((i % 2 == 0) && (a[eeprom_pkg::ADDR_W-1:8] == 3'b000))
                a[eeprom_pkg::ADDR_W-1:8] = 3'((i % 7) + 1);    // exercise block bits
            bits = rand_bits(eeprom_pkg::DATA_W);
            d    = bits[eeprom_pkg::DATA_W-1:0];
            transfer(1'b0, a, d, got);
            transfer(1'b1, a, 8'h00, got);
            check_data($sformatf("rd_data at 0x%03h", a), got, d);
            check_data($sformatf("model mem[0x%03h]", a), model_i.mem[a], d);
        end
        check_level("bad_code", bad_code, 1'b0);
    endtask

    task automatic condition_counts();
        eeprom_pkg::data_t got;
        transfer(1'b0, 11'h7FF, 8'hE1, got);
        transfer(1'b0, 11'h400, 8'h1E, got);
        transfer(1'b1, 11'h7FF, 8'h00, got);
        check_data("rd_data", got, 8'hE1);
    endtask

    task automatic strobe_while_busy();
        int                starts0;
        int                stops0;
        int                dones0;
        eeprom_pkg::data_t got;
        starts0 = start_count;
        stops0  = stop_count;
        dones0  = done_count;
        @(negedge CLK);
        addr    = 11'h3F0;
        wr_data = 8'hA7;
        wr      = 1'b1;
        @(negedge CLK);
        wr = 1'b0;
        repeat (30) @(negedge CLK);    // inside the control byte
        check_level("busy", busy, 1'b1);
        addr = 11'h123;
        rd   = 1'b1;
        @(negedge CLK);
        rd = 1'b0;
        wait_done("write with a read strobe");
        wait_stop(stops0 + 1);
        // a captured read would bring busy back
        for (int i = 0; i < 100; i++)
        begin
            @(negedge CLK);
            check_level("busy", busy, 1'b0);
        end
        check_count("done pulses", done_count - dones0, 1);
        check_count("start_count delta", start_count - starts0, 1);
        transfer(1'b1, 11'h3F0, 8'h00, got);
        check_data("rd_data", got, 8'hA7);
    endtask

    task automatic collision_write_wins();
        int                starts0;
        int                stops0;
        eeprom_pkg::data_t got;
        starts0 = start_count;
        stops0  = stop_count;
        @(negedge CLK);
        addr    = 11'h555;
        wr_data = 8'h96;
        wr      = 1'b1;
        rd      = 1'b1;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        wait_done("colliding strobes");
        wait_stop(stops0 + 1);
        check_count("start_count delta", start_count - starts0, 1);    // a read makes 2
        check_data("model mem[0x555]", model_i.mem[11'h555], 8'h96);
        transfer(1'b1, 11'h555, 8'h00, got);
        check_data("rd_data", got, 8'h96);
    endtask

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        after_reset_state();
        write_then_read();
        random_addresses();
        condition_counts();
        strobe_while_busy();
        collision_write_wins();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: eeprom_master.f
verilog/eeprom_pkg.sv
verilog/eeprom_req_capture.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_bus_driver.sv
verilog/eeprom_master.sv
verification/eeprom_model.sv
verification/eeprom_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the eeprom_master testbench with Verilator, runs it and checks sim.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module eeprom_master_tb -f eeprom_master.f \
    -o eeprom_master_sim > sim.log 2>&1 \
    && ./obj_dir/eeprom_master_sim >> sim.log 2>&1
grep -q "Testbench failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation did not complete, see sim.log"; exit 1; }
echo "simulation passed"
